/* bconv.f */
+incdir+include
hw/bconv_pkg.sv
hw/row_fetch.sv
hw/window_match.sv
hw/row_writer.sv
hw/bconv_top.sv
verification/bconv_checker.sv
verification/bconv_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it, and fails when the log holds the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -f bconv.f --top-module bconv_tb -o bconv_sim > build.log 2>&1 \
	&& ./obj_dir/bconv_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "simulation reported errors"; exit 1; } \
	|| echo "simulation clean"

/* verification/bconv_tb.sv */
// testbench top for the convolution engine: clock, reset, memories, random runs and timeout
`timescale 1ns/1ns
`include "bconv_settings.svh"

module bconv_tb;
	import bconv_pkg::*;

	localparam int mem_depth = 1 << `BCONV_ADDR_W;

	logic clk = 1'b0;
	logic reset_b = 1'b0;
	logic dut_run = 1'b0;
	logic dut_busy;
	addr_t dut_sram_read_address;
	word_t sram_dut_read_data = '0;
	addr_t dut_wmem_read_address;
	word_t wmem_dut_read_data = '0;
	addr_t dut_sram_write_address;
	word_t dut_sram_write_data;
	logic dut_sram_write_enable;

	// input and weight memories
	word_t in_mem [0:mem_depth-1];
	word_t wmem [0:mem_depth-1];

	logic [31:0] lfsr_state = 32'h4d269355;
	int load_addr;
	int cycle_count = 0;
	int cycle_limit;
	int mismatch_count;
	int other_count;
	int row_count;

	always #10 clk = ~clk;

	// ======================================================================
	// DUT, memory models, checker
	// ======================================================================

	bconv_top bconv_top_i (
		.clk(clk),
		.reset_b(reset_b),
		.dut_run(dut_run),
		.dut_busy(dut_busy),
		.dut_sram_read_address(dut_sram_read_address),
		.sram_dut_read_data(sram_dut_read_data),
		.dut_wmem_read_address(dut_wmem_read_address),
		.wmem_dut_read_data(wmem_dut_read_data),
		.dut_sram_write_address(dut_sram_write_address),
		.dut_sram_write_data(dut_sram_write_data),
		.dut_sram_write_enable(dut_sram_write_enable)
	);

	// synchronous read, data one cycle after the address
	always @(posedge clk) begin
		sram_dut_read_data <= in_mem[dut_sram_read_address];
		wmem_dut_read_data <= wmem[dut_wmem_read_address];
	end

	bconv_checker bconv_checker_i (
		.clk(clk),
		.reset_b(reset_b),
		.dut_run(dut_run),
		.dut_busy(dut_busy),
		.dut_sram_write_address(dut_sram_write_address),
		.dut_sram_write_data(dut_sram_write_data),
		.dut_sram_write_enable(dut_sram_write_enable),
		.in_mem(in_mem),
		.kernel_word(wmem[addr_t'(`BCONV_KERNEL_ADDR)]),
		.mismatch_count(mismatch_count),
		.other_count(other_count),
		.row_count(row_count)
	);

	// run limit grows as matrices are loaded
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout after %0d cycles, the engine did not finish", cycle_count);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// ======================================================================
	// random source and stimulus tasks
	// ======================================================================

	// galois step, taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out)
			lfsr_state = lfsr_state ^ 32'h80200003;
		return out;
	endfunction

	function automatic int random_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
			v = (v << 1) | int'(lfsr_bit());
		return v;
	endfunction

	// fresh memories and a new kernel, written away from the clock edge
	task automatic start_image();
		@(negedge clk);
		for (int a = 0; a < mem_depth; a++) begin
			in_mem[addr_t'(a)] = word_t'({a[3:0], a[11:0]}) ^ 16'hc35a;
			wmem[addr_t'(a)] = ~word_t'({a[11:0], a[3:0]});
		end
		// dims word, never read
		wmem[0] = 16'h0303;
		wmem[addr_t'(`BCONV_KERNEL_ADDR)] = word_t'(random_bits(16));
		load_addr = 0;
		cycle_limit = cycle_limit + 100;
	endtask

	task automatic add_matrix(input int rows, input int cols);
		in_mem[addr_t'(load_addr)] = word_t'(rows);
		in_mem[addr_t'(load_addr + 1)] = word_t'(cols);
		for (int i = 0; i < rows; i++)
			in_mem[addr_t'(load_addr + 2 + i)] = word_t'(random_bits(16));
		load_addr = load_addr + 2 + rows;
		cycle_limit = cycle_limit + (rows + 2) * (cols + 4) + 100;
	endtask

	task automatic add_random_matrix();
		int rows;
		int cols;
		rows = 3 + random_bits(4) % 14;
		cols = 3 + random_bits(4) % 14;
		add_matrix(rows, cols);
	endtask

	// close the list, start, and wait for busy to drop
	task automatic run_engine();
		in_mem[addr_t'(load_addr)] = `BCONV_END_MARKER;
		@(posedge clk);
		dut_run <= 1'b1;
		@(posedge clk);
		while (!dut_busy)
			@(posedge clk);
		dut_run <= 1'b0;
		while (dut_busy)
			@(posedge clk);
		repeat (4) @(posedge clk);
	endtask

	// ======================================================================
	// test sequence
	// ======================================================================

	initial begin
		cycle_limit = 60;
		repeat (5) @(posedge clk);
		reset_b <= 1'b1;
		// quiet idle, no start yet
		repeat (10) @(posedge clk);

		// one random matrix
		start_image();
		add_random_matrix();
		run_engine();

		// three matrices, output addresses run on
		start_image();
		repeat (3) add_random_matrix();
		run_engine();

		// smallest and largest size
		start_image();
		add_matrix(3, 3);
		add_matrix(16, 16);
		run_engine();

		// empty list, then a normal run from address 0 again
		start_image();
		run_engine();
		start_image();
		add_random_matrix();
		run_engine();

		$display("rows checked %0d, mismatches %0d, other errors %0d",
			row_count, mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0 && row_count > 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* verification/bconv_checker.sv */
// testbench checker: models every output row from the input memory and compares each write
`timescale 1ns/1ns
`include "bconv_settings.svh"

module bconv_checker (
	input logic clk,
	input logic reset_b,
	input logic dut_run,
	input logic dut_busy,
	input bconv_pkg::addr_t dut_sram_write_address,
	input bconv_pkg::word_t dut_sram_write_data,
	input logic dut_sram_write_enable,
	input bconv_pkg::word_t in_mem [0:(1 << `BCONV_ADDR_W)-1],
	input bconv_pkg::word_t kernel_word,
	output int mismatch_count,
	output int other_count,
	output int row_count
);
	import bconv_pkg::*;

	localparam int mem_depth = 1 << `BCONV_ADDR_W;

	// expected writes of the current run, in order
	addr_t exp_addr_q [$];
	word_t exp_data_q [$];
	logic busy_q;
	logic run_q;

	// majority of nine for every column of one output row
	function automatic word_t model_row(input int base, input int cols, input kernel_t k);
		word_t res;
		int agree;
		res = '0;
		for (int j = 0; j <= cols - 3; j++) begin
			agree = 0;
			for (int r = 0; r < 3; r++) begin
				for (int c = 0; c < 3; c++) begin
					if (in_mem[addr_t'(base + r)][col_t'(j + c)] == k[4'(3 * r + c)])
						agree++;
				end
			end
			res[col_t'(j)] = (agree >= `BCONV_MAJORITY);
		end
		return res;
	endfunction

	// walk the matrix list up to the end marker
	task automatic build_expected();
		int addr;
		int rows;
		int cols;
		int out_addr;
		exp_addr_q.delete();
		exp_data_q.delete();
		addr = 0;
		out_addr = 0;
		while (addr + 1 < mem_depth && in_mem[addr_t'(addr)] != `BCONV_END_MARKER) begin
			rows = int'(in_mem[addr_t'(addr)]);
			cols = int'(in_mem[addr_t'(addr + 1)]);
			if (rows < 3 || rows > 16 || cols < 3 || cols > 16) begin
				$display("checker: matrix header at address %0d has an unsupported size", addr);
				other_count++;
				addr = mem_depth;
			end else begin
				for (int i = 0; i <= rows - 3; i++) begin
					exp_addr_q.push_back(addr_t'(out_addr));
					exp_data_q.push_back(model_row(addr + 2 + i, cols,
						kernel_word[`BCONV_KERNEL_W-1:0]));
					out_addr++;
				end
				addr = addr + 2 + rows;
			end
		end
	endtask

	always @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			busy_q = 1'b0;
			run_q = 1'b0;
			mismatch_count = 0;
			other_count = 0;
			row_count = 0;
		end else begin
			// start of a run
			if (dut_busy && !busy_q) begin
				if (!run_q) begin
					$display("checker: dut_busy went high without dut_run");
					other_count++;
				end
				build_expected();
			end
			if (dut_sram_write_enable) begin
				if (!dut_busy) begin
					$display("checker: output write while dut_busy is low");
					other_count++;
				end
				if (exp_addr_q.size() == 0) begin
					$display("checker: unexpected write to address %h", dut_sram_write_address);
					other_count++;
				end else begin
					if (dut_sram_write_address !== exp_addr_q[0]) begin
						$display("CHECK FAILED dut_sram_write_address: got %h expected %h",
							dut_sram_write_address, exp_addr_q[0]);
						mismatch_count++;
					end
					if (dut_sram_write_data !== exp_data_q[0]) begin
						$display("CHECK FAILED dut_sram_write_data: got %h expected %h at %h",
							dut_sram_write_data, exp_data_q[0], exp_addr_q[0]);
						mismatch_count++;
					end
					void'(exp_addr_q.pop_front());
					void'(exp_data_q.pop_front());
					row_count++;
				end
			end
			// end of a run, nothing may be left over
			if (!dut_busy && busy_q && exp_addr_q.size() != 0) begin
				$display("checker: run ended with %0d output rows never written",
					exp_addr_q.size());
				other_count++;
				exp_addr_q.delete();
				exp_data_q.delete();
			end
			busy_q = dut_busy;
			run_q = dut_run;
		end
	end

endmodule

/* hw/bconv_top.sv */
// top level of the binary 3x3 convolution engine; connects fetch, match and writer to memories
`timescale 1ns/1ns

module bconv_top (
	input logic clk,
	input logic reset_b,
	input logic dut_run,
	output logic dut_busy,
	output bconv_pkg::addr_t dut_sram_read_address,
	input bconv_pkg::word_t sram_dut_read_data,
	output bconv_pkg::addr_t dut_wmem_read_address,
	input bconv_pkg::word_t wmem_dut_read_data,
	output bconv_pkg::addr_t dut_sram_write_address,
	output bconv_pkg::word_t dut_sram_write_data,
	output logic dut_sram_write_enable
);
	import bconv_pkg::*;

	// fetch -> match
	kernel_t kernel;
	kernel_t window;
	col_t window_col;
	logic window_valid;
	logic row_end;
	addr_t out_addr;

	// match -> writer
	logic bit_value;
	col_t bit_col;
	logic bit_valid;
	logic bit_row_end;
	addr_t bit_addr;

	// writer -> fetch, holds drain
	logic matrix_done_pending;

	// input side, memory reads and window sweep
	row_fetch row_fetch_i (
		.clk(clk),
		.reset_b(reset_b),
		.dut_run(dut_run),
		.sram_dut_read_data(sram_dut_read_data),
		.wmem_dut_read_data(wmem_dut_read_data),
		.matrix_done_pending(matrix_done_pending),
		.dut_busy(dut_busy),
		.dut_sram_read_address(dut_sram_read_address),
		.dut_wmem_read_address(dut_wmem_read_address),
		.kernel(kernel),
		.window(window),
		.window_col(window_col),
		.window_valid(window_valid),
		.row_end(row_end),
		.out_addr(out_addr)
	);

	// two-stage majority decision
	window_match window_match_i (
		.clk(clk),
		.reset_b(reset_b),
		.kernel(kernel),
		.window(window),
		.window_col(window_col),
		.window_valid(window_valid),
		.row_end(row_end),
		.out_addr(out_addr),
		.bit_value(bit_value),
		.bit_col(bit_col),
		.bit_valid(bit_valid),
		.bit_row_end(bit_row_end),
		.bit_addr(bit_addr)
	);

	// output row assembly and write
	row_writer row_writer_i (
		.clk(clk),
		.reset_b(reset_b),
		.bit_value(bit_value),
		.bit_col(bit_col),
		.bit_valid(bit_valid),
		.bit_row_end(bit_row_end),
		.bit_addr(bit_addr),
		.dut_sram_write_address(dut_sram_write_address),
		.dut_sram_write_data(dut_sram_write_data),
		.dut_sram_write_enable(dut_sram_write_enable),
		.matrix_done_pending(matrix_done_pending)
	);

endmodule

/* hw/row_writer.sv */
// output side: collects decision bits into a row word and writes it once per output row
`timescale 1ns/1ns

module row_writer (
	input logic clk,
	input logic reset_b,
	input logic bit_value,
	input bconv_pkg::col_t bit_col,
	input logic bit_valid,
	input logic bit_row_end,
	input bconv_pkg::addr_t bit_addr,
	output bconv_pkg::addr_t dut_sram_write_address,
	output bconv_pkg::word_t dut_sram_write_data,
	output logic dut_sram_write_enable,
	output logic matrix_done_pending
);
	import bconv_pkg::*;

	// row under assembly, unused high bits stay zero
	word_t row_q;
	word_t row_next;
	// some bits of the current row already taken
	logic row_open;

	always_comb begin
		row_next = row_q;
		row_next[bit_col] = bit_value;
	end

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			row_q <= '0;
			row_open <= 1'b0;
			dut_sram_write_enable <= 1'b0;
		end else begin
			dut_sram_write_enable <= bit_valid && bit_row_end;
			if (bit_valid) begin
				// row end clears for the next row
				if (bit_row_end) begin
					row_q <= '0;
					row_open <= 1'b0;
				end else begin
					row_q <= row_next;
					row_open <= 1'b1;
				end
			end
		end
	end

	// write word and address, taken on the row end bit
	always_ff @(posedge clk) begin
		if (bit_valid && bit_row_end) begin
			dut_sram_write_data <= row_next;
			dut_sram_write_address <= bit_addr;
		end
	end

	// busy with a row: bits taken, one arriving, or its write going out
	assign matrix_done_pending = row_open || bit_valid || dut_sram_write_enable;

endmodule

/* hw/window_match.sv */
// processing part: pipelined agreement count of window against kernel with majority decision
`timescale 1ns/1ns
`include "bconv_settings.svh"

module window_match (
	input logic clk,
	input logic reset_b,
	input bconv_pkg::kernel_t kernel,
	input bconv_pkg::kernel_t window,
	input bconv_pkg::col_t window_col,
	input logic window_valid,
	input logic row_end,
	input bconv_pkg::addr_t out_addr,
	output logic bit_value,
	output bconv_pkg::col_t bit_col,
	output logic bit_valid,
	output logic bit_row_end,
	output bconv_pkg::addr_t bit_addr
);
	import bconv_pkg::*;

	// matching bits in one kernel row, 0..3
	function automatic logic [1:0] row_agree(input logic [2:0] w, input logic [2:0] k);
		logic [2:0] same;
		same = ~(w ^ k);
		return {1'b0, same[0]} + {1'b0, same[1]} + {1'b0, same[2]};
	endfunction

	// ======================================================================
	// stage 1, per-row counts
	// ======================================================================

	logic [1:0] s1_count [0:2];
	logic s1_valid;
	logic s1_row_end;
	col_t s1_col;
	addr_t s1_addr;

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			s1_valid <= 1'b0;
			bit_valid <= 1'b0;
		end else begin
			s1_valid <= window_valid;
			bit_valid <= s1_valid;
		end
	end

	// counts and tags follow the valid bits
	always_ff @(posedge clk) begin
		for (int r = 0; r < 3; r++) begin
			s1_count[r] <= row_agree(window[3*r +: 3], kernel[3*r +: 3]);
		end
		s1_col <= window_col;
		s1_row_end <= row_end;
		s1_addr <= out_addr;
	end

	// ======================================================================
	// stage 2, sum and threshold
	// ======================================================================

	count_t agree_sum;

	assign agree_sum = count_t'(s1_count[0]) + count_t'(s1_count[1]) + count_t'(s1_count[2]);

	always_ff @(posedge clk) begin
		// majority of nine
		bit_value <= (agree_sum >= count_t'(`BCONV_MAJORITY));
		bit_col <= s1_col;
		bit_row_end <= s1_row_end;
		bit_addr <= s1_addr;
	end

endmodule

/* hw/row_fetch.sv */
// input side of the engine that reads matrices and the kernel and sweeps 3x3 windows over three rows
`timescale 1ns/1ns
`include "bconv_settings.svh"

module row_fetch (
	input logic clk,
	input logic reset_b,
	input logic dut_run,
	input bconv_pkg::word_t sram_dut_read_data,
	input bconv_pkg::word_t wmem_dut_read_data,
	input logic matrix_done_pending,
	output logic dut_busy,
	output bconv_pkg::addr_t dut_sram_read_address,
	output bconv_pkg::addr_t dut_wmem_read_address,
	output bconv_pkg::kernel_t kernel,
	output bconv_pkg::kernel_t window,
	output bconv_pkg::col_t window_col,
	output logic window_valid,
	output logic row_end,
	output bconv_pkg::addr_t out_addr
);
	import bconv_pkg::*;

	// ======================================================================
	// state and counters
	// ======================================================================

	fetch_state_t state;
	// address presented to input memory with data back one cycle later
	addr_t in_addr;
	// current sweep column and output row within the matrix
	col_t col;
	col_t row_idx;
	// which of the three rows is being loaded
	logic [1:0] fill_cnt;

	// sweep limits rows-3 and cols-3
	col_t last_row;
	col_t last_col;
	// the three input rows under the window
	word_t row_q [0:2];

	// size word minus three gives the last window index
	col_t size_m3;
	logic end_seen;

	assign size_m3 = sram_dut_read_data[`BCONV_COL_W-1:0] - col_t'(3);
	assign end_seen = (sram_dut_read_data == word_t'(`BCONV_END_MARKER));

	// input address straight from counter
	assign dut_sram_read_address = in_addr;
	// only the kernel word is ever read
	assign dut_wmem_read_address = addr_t'(`BCONV_KERNEL_ADDR);

	// ======================================================================
	// control
	// ======================================================================

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			state <= idle;
			dut_busy <= 1'b0;
			in_addr <= '0;
			out_addr <= '0;
			col <= '0;
			row_idx <= '0;
			fill_cnt <= '0;
		end else begin
			case (state)
				idle: begin
					out_addr <= '0;
					col <= '0;
					row_idx <= '0;
					// address 0 already presented so step to the cols word on start
					if (dut_run) begin
						in_addr <= addr_t'(1);
						dut_busy <= 1'b1;
						state <= read_rows;
					end else begin
						in_addr <= '0;
					end
				end
				read_rows: begin
					// rows word on the bus now
					if (end_seen) begin
						state <= drain;
					end else begin
						in_addr <= in_addr + addr_t'(1);
						state <= read_cols;
					end
				end
				read_cols: begin
					// first row address stays presented one more cycle
					state <= read_kernel;
				end
				read_kernel: begin
					in_addr <= in_addr + addr_t'(1);
					fill_cnt <= '0;
					state <= fill;
				end
				fill: begin
					// third row in and the address now points at the next row
					if (fill_cnt == 2'd2) begin
						state <= sweep;
					end else begin
						in_addr <= in_addr + addr_t'(1);
						fill_cnt <= fill_cnt + 2'd1;
					end
				end
				sweep: begin
					if (col == last_col) begin
						col <= '0;
						out_addr <= out_addr + addr_t'(1);
						// after the last output row in_addr sits on the next rows word
						if (row_idx == last_row) begin
							row_idx <= '0;
							in_addr <= in_addr + addr_t'(1);
							state <= read_rows;
						end else begin
							state <= next_row;
						end
					end else begin
						col <= col + col_t'(1);
					end
				end
				next_row: begin
					in_addr <= in_addr + addr_t'(1);
					row_idx <= row_idx + col_t'(1);
					state <= sweep;
				end
				drain: begin
					// wait for the last row to leave the writer
					if (!matrix_done_pending) begin
						dut_busy <= 1'b0;
						in_addr <= '0;
						out_addr <= '0;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// ======================================================================
	// sizes, kernel and row registers
	// ======================================================================

	always_ff @(posedge clk) begin
		case (state)
			read_rows: last_row <= size_m3;
			read_cols: last_col <= size_m3;
			read_kernel: kernel <= wmem_dut_read_data[`BCONV_KERNEL_W-1:0];
			fill: row_q[fill_cnt] <= sram_dut_read_data;
			next_row: begin
				// rows move up and the new row enters at the bottom
				row_q[0] <= row_q[1];
				row_q[1] <= row_q[2];
				row_q[2] <= sram_dut_read_data;
			end
			default: ;
		endcase
	end

	// window bit 3*r+c is row r and column col+c
	always_comb begin
		col_t pos;
		window = '0;
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				pos = col + col_t'(c);
				window[3*r+c] = row_q[r][pos];
			end
		end
	end

	assign window_col = col;
	assign window_valid = (state == sweep);
	assign row_end = window_valid && (col == last_col);

endmodule

/* hw/bconv_pkg.sv */
// types shared by the convolution engine modules; import inside a module body or use scoped
`include "bconv_settings.svh"

package bconv_pkg;

	// memory address
	typedef logic [`BCONV_ADDR_W-1:0] addr_t;
	// memory word or image row
	typedef logic [`BCONV_WORD_W-1:0] word_t;
	// column index inside a row
	typedef logic [`BCONV_COL_W-1:0] col_t;
	// kernel or 3x3 window, bit 3*r+c
	typedef logic [`BCONV_KERNEL_W-1:0] kernel_t;
	// agreement count 0..9
	typedef logic [$clog2(`BCONV_KERNEL_W+1)-1:0] count_t;

	// row_fetch control states
	typedef enum logic [2:0] {
		idle,
		read_rows,
		read_cols,
		read_kernel,
		fill,
		sweep,
		next_row,
		drain
	} fetch_state_t;

endpackage

/* include/bconv_settings.svh */
// shared widths, addresses and limits for the binary convolution engine; include where needed
`ifndef BCONV_SETTINGS_SVH
`define BCONV_SETTINGS_SVH

// ======================================================================
// widths
// ======================================================================

// memory address width
`define BCONV_ADDR_W 12
// memory word, one image row
`define BCONV_WORD_W 16
// column index within a row
`define BCONV_COL_W 4
// 3x3 kernel, bit 3*r+c
`define BCONV_KERNEL_W 9

// ======================================================================
// memory map and limits
// ======================================================================

// kernel lives at weight address 1, dims word at 0 is ignored
`define BCONV_KERNEL_ADDR 1
// rows word that ends a run
`define BCONV_END_MARKER 16'h00FF
// at least this many agreeing bits gives a 1
`define BCONV_MAJORITY 5

`endif
